//--- rtl/cpu_arch_pkg.sv
package cpu_arch_pkg;

	// byte address, no translation in this core
	typedef logic [31:0] addr_t;

	// boot rom, first word fetched after reset
	localparam addr_t RESET_VECTOR = 32'hBFC0_0000;

	// exception flags, one bit per cause
	// bit 0 interrupt, bit 1 fetch address error, upper bits for later stages
	localparam int EXC_W    = 8;
	localparam int EXC_ADEL = 1;

	typedef logic [EXC_W-1:0] excs_t;

	// kseg1, unmapped and uncached
	localparam addr_t KSEG1_BASE = 32'hA000_0000;
	localparam addr_t KSEG1_TOP  = 32'hBFFF_FFFF;

	function automatic logic in_kseg1(addr_t a);
		return (a >= KSEG1_BASE) && (a <= KSEG1_TOP);
	endfunction

	// instructions must sit on a word boundary
	function automatic logic word_aligned(addr_t a);
		return a[1:0] == 2'b00;
	endfunction

endpackage

//--- rtl/fetch_cfg_pkg.sv
package fetch_cfg_pkg;

	typedef logic [31:0] inst_t;

	// all zero word decodes as a nop
	localparam inst_t INST_NOP = 32'h0000_0000;

	// byte offset inside a one-word line
	localparam int WORD_OFS_W = 2;

	// index bits for a power of two line count
	function automatic int index_w(int lines);
		return $clog2(lines);
	endfunction

	// what is left of the address above index and offset
	function automatic int tag_w(int lines);
		return $bits(cpu_arch_pkg::addr_t) - index_w(lines) - WORD_OFS_W;
	endfunction

endpackage

//--- rtl/fetch_pc.sv
`timescale 1ns/100ps

module fetch_pc (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 stall_i,
	input  logic                 branch_i,
	input  cpu_arch_pkg::addr_t  branch_target_i,
	input  logic                 flush_i,
	input  cpu_arch_pkg::addr_t  flush_target_i,
	input  logic                 inslot_i,
	input  fetch_cfg_pkg::inst_t cache_inst_i,
	input  logic                 hit_valid_i,
	input  logic                 lookup_stall_i,
	input  logic                 mem_wait_stall_i,
	output cpu_arch_pkg::addr_t  fetch_addr_o,
	output logic                 fetch_en_o,
	output cpu_arch_pkg::addr_t  if_pc_o,
	output fetch_cfg_pkg::inst_t if_inst_o,
	output logic                 if_valid_o,
	output logic                 if_inslot_o,
	output cpu_arch_pkg::excs_t  if_excs_o,
	output logic                 if_has_exc_o
);
	import cpu_arch_pkg::*;
	import fetch_cfg_pkg::*;

	addr_t pc_q;
	addr_t pc_d;
	addr_t flush_pc_q;
	addr_t branch_pc_q;
	logic  flush_pend_q;
	logic  branch_pend_q;
	logic  slot_pend_q;

	logic  cache_stall;
	logic  misaligned;
	logic  pend_any;
	logic  deliver;
	logic  discard;
	logic  consume;

	logic  valid_d;
	logic  inslot_d;
	inst_t inst_d;
	excs_t excs_d;

	assign cache_stall = lookup_stall_i | mem_wait_stall_i;
	assign misaligned  = !word_aligned(pc_q);

	// no cache access for a bad address or while decode is stalled
	assign fetch_en_o   = !stall_i && !misaligned;
	assign fetch_addr_o = pc_q;

	assign pend_any = flush_pend_q | branch_pend_q;

	// an instruction (or an address error) is ready for decode
	assign deliver = !cache_stall && !stall_i && (hit_valid_i || misaligned);

	// the word behind a latched redirect is the one fetched during the stall
	assign discard = flush_i || pend_any;

	// latched redirects are used up once fetch moves again
	assign consume = deliver || (!cache_stall && (flush_i || branch_i));

	always_comb begin
		pc_d = pc_q;
		if (!cache_stall && flush_i) begin
			pc_d = flush_target_i;
		end else if (!cache_stall && branch_i) begin
			pc_d = branch_target_i;
		end else if (deliver) begin
			if (flush_pend_q)
				pc_d = flush_pc_q;
			else if (branch_pend_q)
				pc_d = branch_pc_q;
			else
				pc_d = pc_q + 32'd4; // sequential
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc_q <= RESET_VECTOR;
		else
			pc_q <= pc_d;
	end

	// redirects seen while the cache holds the pipe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flush_pend_q  <= 1'b0;
			branch_pend_q <= 1'b0;
			slot_pend_q   <= 1'b0;
		end else if (consume) begin
			flush_pend_q  <= 1'b0;
			branch_pend_q <= 1'b0;
			slot_pend_q   <= 1'b0;
		end else if (cache_stall) begin
			if (flush_i)
				flush_pend_q <= 1'b1;
			if (branch_i)
				branch_pend_q <= 1'b1;
			if (inslot_i)
				slot_pend_q <= 1'b1; // inslot_i may drop before the word arrives
		end
	end

	always_ff @(posedge clk) begin
		if (cache_stall && flush_i)
			flush_pc_q <= flush_target_i;
		if (cache_stall && branch_i)
			branch_pc_q <= branch_target_i;
	end

	always_comb begin
		valid_d  = deliver && !discard;
		inslot_d = valid_d && (inslot_i || slot_pend_q);
		inst_d   = INST_NOP;
		excs_d   = '0;
		if (valid_d) begin
			if (misaligned)
				excs_d[EXC_ADEL] = 1'b1; // adel, word stays zero
			else
				inst_d = cache_inst_i;
		end
	end

	// decode side registers, frozen by stall_i
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			if_valid_o   <= 1'b0;
			if_inslot_o  <= 1'b0;
			if_excs_o    <= '0;
			if_has_exc_o <= 1'b0;
		end else if (!stall_i) begin
			if_valid_o   <= valid_d;
			if_inslot_o  <= inslot_d;
			if_excs_o    <= excs_d;
			if_has_exc_o <= |excs_d;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i) begin
			if_pc_o   <= pc_q;
			if_inst_o <= inst_d; // zero on flush or bubble
		end
	end

endmodule

//--- rtl/icache.sv
`timescale 1ns/100ps

module icache #(
	parameter int LINES = 64
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  cpu_arch_pkg::addr_t  fetch_addr_i,
	input  logic                 fetch_en_i,
	input  logic                 mem_valid_i,
	input  fetch_cfg_pkg::inst_t mem_rdata_i,
	output fetch_cfg_pkg::inst_t cache_inst_o,
	output logic                 hit_valid_o,
	output logic                 lookup_stall_o,
	output logic                 mem_wait_stall_o,
	output logic                 mem_req_o,
	output cpu_arch_pkg::addr_t  mem_addr_o
);
	import cpu_arch_pkg::*;
	import fetch_cfg_pkg::*;

	localparam int IDX_W = index_w(LINES);
	localparam int TAG_W = tag_w(LINES);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_WAIT
	} state_t;

	state_t state_q;
	state_t state_d;

	logic [TAG_W-1:0] tag_mem [LINES];
	inst_t            data_mem [LINES];
	logic [LINES-1:0] valid_q;

	addr_t            miss_addr_q;
	logic             miss_unc_q;  // outstanding read bypasses the array

	logic [IDX_W-1:0] rd_idx;
	logic [TAG_W-1:0] rd_tag;
	logic [IDX_W-1:0] wr_idx;
	logic [TAG_W-1:0] wr_tag;

	logic             uncached;
	logic             hit;
	logic             busy;
	logic             data_back;
	logic             miss_start;
	logic             unc_start;
	logic             line_write;

	assign rd_idx = fetch_addr_i[WORD_OFS_W +: IDX_W];
	assign rd_tag = fetch_addr_i[WORD_OFS_W + IDX_W +: TAG_W];
	assign wr_idx = miss_addr_q[WORD_OFS_W +: IDX_W];
	assign wr_tag = miss_addr_q[WORD_OFS_W + IDX_W +: TAG_W];

	assign uncached = in_kseg1(fetch_addr_i);
	assign hit      = !uncached && valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);

	assign busy      = (state_q != ST_IDLE);
	assign data_back = (state_q == ST_WAIT) && mem_valid_i;

	// a new read only starts from idle
	assign miss_start = (state_q == ST_IDLE) && fetch_en_i && !uncached && !hit;
	assign unc_start  = (state_q == ST_IDLE) && fetch_en_i && uncached;

	assign line_write = data_back && !miss_unc_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (miss_start || unc_start)
					state_d = ST_REQ;
			end
			ST_REQ: begin
				state_d = ST_WAIT; // request goes out this cycle
			end
			ST_WAIT: begin
				if (mem_valid_i)
					state_d = ST_IDLE;
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q    <= ST_IDLE;
			miss_unc_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (miss_start || unc_start)
				miss_unc_q <= uncached;
		end
	end

	always_ff @(posedge clk) begin
		if (miss_start || unc_start)
			miss_addr_q <= fetch_addr_i;
	end

	// refill, one word per line
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
			for (int i = 0; i < LINES; i++) begin
				tag_mem[i]  <= '0;
				data_mem[i] <= '0;
			end
		end else if (line_write) begin
			valid_q[wr_idx]  <= 1'b1;
			tag_mem[wr_idx]  <= wr_tag;
			data_mem[wr_idx] <= mem_rdata_i;
		end
	end

	// uncached word goes straight through on the return cycle
	assign cache_inst_o = (data_back && miss_unc_q) ? mem_rdata_i : data_mem[rd_idx];
	assign hit_valid_o  = ((state_q == ST_IDLE) && fetch_en_i && hit) ||
	                      (data_back && miss_unc_q);

	// cached miss holds fetch until the hit after the refill
	assign lookup_stall_o   = miss_start || (busy && !miss_unc_q);
	assign mem_wait_stall_o = unc_start || (busy && !data_back);

	assign mem_req_o  = (state_q == ST_REQ);
	assign mem_addr_o = miss_addr_q;

endmodule

//--- rtl/fetch_top.sv
`timescale 1ns/100ps

module fetch_top #(
	parameter int LINES = 64
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 stall_i,
	input  logic                 branch_i,
	input  cpu_arch_pkg::addr_t  branch_target_i,
	input  logic                 flush_i,
	input  cpu_arch_pkg::addr_t  flush_target_i,
	input  logic                 inslot_i,
	input  logic                 mem_valid_i,
	input  fetch_cfg_pkg::inst_t mem_rdata_i,
	output cpu_arch_pkg::addr_t  if_pc_o,
	output fetch_cfg_pkg::inst_t if_inst_o,
	output logic                 if_valid_o,
	output logic                 if_inslot_o,
	output cpu_arch_pkg::excs_t  if_excs_o,
	output logic                 if_has_exc_o,
	output logic                 mem_req_o,
	output cpu_arch_pkg::addr_t  mem_addr_o
);
	import cpu_arch_pkg::*;
	import fetch_cfg_pkg::*;

	addr_t fetch_addr;
	logic  fetch_en;
	inst_t cache_inst;
	logic  hit_valid;
	logic  lookup_stall;
	logic  mem_wait_stall;

	fetch_pc u_fetch_pc (
		.clk              (clk),
		.rst_n            (rst_n),
		.stall_i          (stall_i),
		.branch_i         (branch_i),
		.branch_target_i  (branch_target_i),
		.flush_i          (flush_i),
		.flush_target_i   (flush_target_i),
		.inslot_i         (inslot_i),
		.cache_inst_i     (cache_inst),
		.hit_valid_i      (hit_valid),
		.lookup_stall_i   (lookup_stall),
		.mem_wait_stall_i (mem_wait_stall),
		.fetch_addr_o     (fetch_addr),
		.fetch_en_o       (fetch_en),
		.if_pc_o          (if_pc_o),
		.if_inst_o        (if_inst_o),
		.if_valid_o       (if_valid_o),
		.if_inslot_o      (if_inslot_o),
		.if_excs_o        (if_excs_o),
		.if_has_exc_o     (if_has_exc_o)
	);

	icache #(
		.LINES (LINES)
	) u_icache (
		.clk              (clk),
		.rst_n            (rst_n),
		.fetch_addr_i     (fetch_addr),
		.fetch_en_i       (fetch_en),
		.mem_valid_i      (mem_valid_i),
		.mem_rdata_i      (mem_rdata_i),
		.cache_inst_o     (cache_inst),
		.hit_valid_o      (hit_valid),
		.lookup_stall_o   (lookup_stall),
		.mem_wait_stall_o (mem_wait_stall),
		.mem_req_o        (mem_req_o),
		.mem_addr_o       (mem_addr_o)
	);

endmodule

//--- tb/fetch_mem_model.sv
`timescale 1ns/100ps

module fetch_mem_model (
	input  logic                 clk,
	input  logic                 mem_req_i,
	input  cpu_arch_pkg::addr_t  mem_addr_i,
	output logic                 mem_valid_o,
	output fetch_cfg_pkg::inst_t mem_rdata_o
);
	import cpu_arch_pkg::*;
	import fetch_cfg_pkg::*;

	localparam int LATENCY = 3;

	addr_t req_addr;

	initial begin
		mem_valid_o = 1'b0;
		mem_rdata_o = '0;
		forever begin
			@(negedge clk); // request and address are stable mid cycle
			if (mem_req_i) begin
				req_addr = mem_addr_i;
				repeat (LATENCY) @(posedge clk);
				#2;
				mem_valid_o = 1'b1;
				mem_rdata_o = req_addr ^ 32'h5A5A_0000; // data follows the address
				@(posedge clk);
				#2;
				mem_valid_o = 1'b0;
				mem_rdata_o = '0;
			end
		end
	end

endmodule

//--- tb/fetch_properties.sv
`timescale 1ns/100ps

module fetch_properties (
	input logic                clk,
	input logic                rst_n,
	input logic                mem_req_i,
	input logic                mem_valid_i,
	input logic                if_valid_i,
	input logic                if_inslot_i,
	input cpu_arch_pkg::excs_t if_excs_i,
	input logic                if_has_exc_i
);
	import cpu_arch_pkg::*;

	logic outstanding_q; // read issued, data not back yet

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			outstanding_q <= 1'b0;
		else if (mem_req_i)
			outstanding_q <= 1'b1;
		else if (mem_valid_i)
			outstanding_q <= 1'b0;
	end

	req_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req_i |=> !mem_req_i)
		else $error("mem_req_o held longer than one cycle");

	req_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_req_i && outstanding_q))
		else $error("mem_req_o while a read is outstanding");

	has_exc_is_or: assert property (@(posedge clk) disable iff (!rst_n)
		if_has_exc_i == (|if_excs_i))
		else $error("if_has_exc_o differs from the OR of if_excs_o");

	quiet_in_reset: assert property (@(posedge clk)
		!rst_n |-> !if_valid_i && !if_inslot_i && !if_has_exc_i && !mem_req_i &&
			(if_excs_i == '0))
		else $error("control output high during reset");

endmodule

//--- tb/tb_fetch.sv
`timescale 1ns/100ps

module tb_fetch;
	import cpu_arch_pkg::*;
	import fetch_cfg_pkg::*;

	localparam int MAX_CYCLES = 4000;
	localparam int WAIT_LIMIT = 60;

	logic  clk;
	logic  rst_n;
	logic  stall_i;
	logic  branch_i;
	addr_t branch_target_i;
	logic  flush_i;
	addr_t flush_target_i;
	logic  inslot_i;
	logic  mem_valid_i;
	inst_t mem_rdata_i;
	addr_t if_pc_o;
	inst_t if_inst_o;
	logic  if_valid_o;
	logic  if_inslot_o;
	excs_t if_excs_o;
	logic  if_has_exc_o;
	logic  mem_req_o;
	addr_t mem_addr_o;

	int    cycles;
	int    err_count;
	int    check_count;
	int    test_count;
	int    req_total;
	int    win_reqs;
	addr_t win_lo;
	addr_t win_hi;
	addr_t loop_base;

	fetch_top #(.LINES(64)) dut0 (
		.clk(clk), .rst_n(rst_n), .stall_i(stall_i),
		.branch_i(branch_i), .branch_target_i(branch_target_i),
		.flush_i(flush_i), .flush_target_i(flush_target_i), .inslot_i(inslot_i),
		.mem_valid_i(mem_valid_i), .mem_rdata_i(mem_rdata_i),
		.if_pc_o(if_pc_o), .if_inst_o(if_inst_o), .if_valid_o(if_valid_o),
		.if_inslot_o(if_inslot_o), .if_excs_o(if_excs_o), .if_has_exc_o(if_has_exc_o),
		.mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o)
	);

	fetch_mem_model mem0 (
		.clk(clk), .mem_req_i(mem_req_o), .mem_addr_i(mem_addr_o),
		.mem_valid_o(mem_valid_i), .mem_rdata_o(mem_rdata_i)
	);

	bind fetch_top fetch_properties props0 (
		.clk(clk), .rst_n(rst_n), .mem_req_i(mem_req_o), .mem_valid_i(mem_valid_i),
		.if_valid_i(if_valid_o), .if_inslot_i(if_inslot_o),
		.if_excs_i(if_excs_o), .if_has_exc_i(if_has_exc_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES) begin
			$display("run stopped, no result after %0d cycles", MAX_CYCLES);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// count memory reads, overall and inside a watched address window
	always @(negedge clk) begin
		if (rst_n && mem_req_o) begin
			req_total++;
			if (mem_addr_o >= win_lo && mem_addr_o <= win_hi)
				win_reqs++;
		end
	end

	function automatic inst_t mem_word(addr_t a);
		return a ^ 32'h5A5A_0000;
	endfunction

	task automatic step();
		@(posedge clk);
		#2;
	endtask

	task automatic check_addr(string name, addr_t got, addr_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("ERROR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_inst(string name, inst_t got, inst_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("ERROR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_excs(string name, excs_t got, excs_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("ERROR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("ERROR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_count_eq(string name, int got, int exp);
		check_count++;
		if (got != exp) begin
			err_count++;
			$display("ERROR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic wait_valid();
		int n;
		n = 0;
		do begin
			step();
			n++;
		end while (!if_valid_o && n < WAIT_LIMIT);
		if (!if_valid_o) begin
			err_count++;
			$display("no valid instruction came out within %0d cycles", WAIT_LIMIT);
		end
	endtask

	task automatic wait_req(addr_t a);
		int n;
		n = 0;
		do begin
			step();
			n++;
		end while (!(mem_req_o && mem_addr_o == a) && n < WAIT_LIMIT);
		if (!(mem_req_o && mem_addr_o == a)) begin
			err_count++;
			$display("memory read for %h never started", a);
		end
	endtask

	task automatic pulse_branch(addr_t a);
		branch_i        = 1'b1;
		branch_target_i = a;
		step();
		branch_i        = 1'b0;
	endtask

	// one older word may still come out when the branch is taken at once
	task automatic expect_redirect(addr_t a);
		wait_valid();
		if (if_pc_o !== a)
			wait_valid();
		check_addr("if_pc_o", if_pc_o, a);
	endtask

	task automatic expect_word(addr_t a);
		wait_valid();
		check_addr("if_pc_o", if_pc_o, a);
		check_inst("if_inst_o", if_inst_o, mem_word(a));
		check_excs("if_excs_o", if_excs_o, '0);
	endtask

	task automatic report(string name, int errs_before);
		test_count++;
		$display("test %s finished with %0d errors", name, err_count - errs_before);
	endtask

	task automatic run_reset_fetch();
		int e0;
		e0 = err_count;
		check_flag("if_valid_o", if_valid_o, 1'b0);
		check_flag("if_has_exc_o", if_has_exc_o, 1'b0);
		check_flag("if_inslot_o", if_inslot_o, 1'b0);
		check_flag("mem_req_o", mem_req_o, 1'b0);
		check_excs("if_excs_o", if_excs_o, '0);
		check_addr("fetch_addr", dut0.u_fetch_pc.fetch_addr_o, RESET_VECTOR);
		for (int k = 0; k < 4; k++)
			expect_word(RESET_VECTOR + 32'(4 * k));
		check_count_eq("mem_req_o count", req_total, 4); // kseg1, one read each
		report("reset_fetch", e0);
	endtask

	task automatic run_cached_loop();
		int e0;
		e0 = err_count;
		win_lo = loop_base;
		win_hi = loop_base + 32'd12;
		pulse_branch(loop_base);
		expect_redirect(loop_base);
		check_inst("if_inst_o", if_inst_o, mem_word(loop_base));
		for (int k = 1; k < 4; k++)
			expect_word(loop_base + 32'(4 * k));
		win_reqs = 0;
		pulse_branch(loop_base);
		expect_redirect(loop_base);
		check_inst("if_inst_o", if_inst_o, mem_word(loop_base));
		for (int k = 1; k < 4; k++)
			expect_word(loop_base + 32'(4 * k));
		check_count_eq("mem_req_o in loop", win_reqs, 0); // second pass all hits
		report("cached_loop", e0);
	endtask

	task automatic run_branch_in_stall();
		int e0;
		e0 = err_count;
		pulse_branch(32'h0000_2080);
		wait_req(32'h0000_2080);
		pulse_branch(32'h0000_20C0); // lands while the miss is outstanding
		expect_word(32'h0000_20C0);
		report("branch_in_stall", e0);
	endtask

	task automatic run_flush();
		int e0;
		e0 = err_count;
		pulse_branch(32'h0000_3090);
		wait_req(32'h0000_3090);
		pulse_branch(32'h0000_30A0);
		flush_i        = 1'b1;
		flush_target_i = 32'h0000_30B0;
		step();
		flush_i = 1'b0;
		expect_word(32'h0000_30B0); // flush beats the branch
		pulse_branch(loop_base);
		expect_redirect(loop_base);
		flush_i        = 1'b1; // loop_base + 4 hits in this cycle
		flush_target_i = 32'h0000_1200;
		step();
		flush_i = 1'b0;
		check_flag("if_valid_o", if_valid_o, 1'b0);
		check_inst("if_inst_o", if_inst_o, '0);
		expect_word(32'h0000_1200);
		report("flush", e0);
	endtask

	task automatic run_misaligned();
		int    e0;
		addr_t tgt;
		excs_t adel;
		e0     = err_count;
		tgt    = loop_base + 32'h0000_0102;
		adel   = '0;
		adel[EXC_ADEL] = 1'b1;
		win_lo = tgt;
		win_hi = tgt + 32'd64;
		win_reqs = 0;
		pulse_branch(tgt);
		expect_redirect(tgt);
		check_excs("if_excs_o", if_excs_o, adel);
		check_flag("if_has_exc_o", if_has_exc_o, 1'b1);
		check_inst("if_inst_o", if_inst_o, '0);
		check_count_eq("mem_req_o misaligned", win_reqs, 0);
		report("misaligned", e0);
	endtask

	task automatic run_slot_and_stall();
		int    e0;
		addr_t pc_hold;
		inst_t inst_hold;
		e0 = err_count;
		pulse_branch(loop_base);
		expect_redirect(loop_base);
		inslot_i = 1'b1;
		wait_valid();
		check_flag("if_inslot_o", if_inslot_o, 1'b1);
		check_addr("if_pc_o", if_pc_o, loop_base + 32'd4);
		check_inst("if_inst_o", if_inst_o, mem_word(loop_base + 32'd4));
		inslot_i  = 1'b0;
		pc_hold   = if_pc_o;
		inst_hold = if_inst_o;
		stall_i   = 1'b1;
		for (int k = 0; k < 5; k++) begin
			step();
			check_addr("if_pc_o", if_pc_o, pc_hold);
			check_inst("if_inst_o", if_inst_o, inst_hold);
			check_flag("if_valid_o", if_valid_o, 1'b1);
			check_flag("if_inslot_o", if_inslot_o, 1'b1);
		end
		stall_i = 1'b0;
		expect_word(loop_base + 32'd8);
		check_flag("if_inslot_o", if_inslot_o, 1'b0);
		report("slot_and_stall", e0);
	endtask

	initial begin
		void'($urandom(32'h20ae2fa7));
		cycles          = 0;
		err_count       = 0;
		check_count     = 0;
		test_count      = 0;
		req_total       = 0;
		win_reqs        = 0;
		win_lo          = '0;
		win_hi          = '0;
		rst_n           = 1'b0;
		stall_i         = 1'b0;
		branch_i        = 1'b0;
		branch_target_i = '0;
		flush_i         = 1'b0;
		flush_target_i  = '0;
		inslot_i        = 1'b0;
		loop_base = 32'h0000_1000 + 32'(($urandom % 16) * 4); // low cache indexes
		repeat (8) step();
		rst_n = 1'b1;

		run_reset_fetch();
		run_cached_loop();
		run_branch_in_stall();
		run_flush();
		run_misaligned();
		run_slot_and_stall();

		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
		if (err_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- sources.f
rtl/cpu_arch_pkg.sv
rtl/fetch_cfg_pkg.sv
rtl/fetch_pc.sv
rtl/icache.sv
rtl/fetch_top.sv
tb/fetch_mem_model.sv
tb/fetch_properties.sv
tb/tb_fetch.sv

//--- sim.sh
#!/bin/sh
# build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_fetch -f sources.f -o sim_fetch &&
	./obj_dir/sim_fetch | tee /dev/stderr | grep -q "^NO ERRORS$" &&
	echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }
